//--- Bender.yml
package:
  name: rvDecode

sources:
  - files:
      - hw/rvDecodePkg.sv
      - hw/controlUnit.sv
      - hw/immExtender.sv
      - hw/registerFile.sv
      - hw/decodeStage.sv
  - target: test
    files:
      - tb/decodeStage_assertions.sv
      - tb/decodeStageTb.sv

//--- hw/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit import rvDecodePkg::*; (
    input  opcodeE     opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    output ctrlT       ctrl,
    output immSrcE     immSrc
);

    // Operation class passed from the main decoder to the ALU decoder.
    typedef enum logic [1:0] {
        aluOpAdd   = 2'b00,
        aluOpSub   = 2'b01,
        aluOpRType = 2'b10,
        aluOpIType = 2'b11
    } aluOpE;

    aluOpE aluOp;

    // Main decoder.
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.jump = 1'b0;
        ctrl.branch = 1'b0;
        ctrl.aluSrc = 1'b0;
        ctrl.resultSrc = resAlu;
        immSrc = immI;
        aluOp = aluOpAdd;
        case (opcode)
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.resultSrc = resMem;
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                immSrc = immS;
            end
            opRType: begin
                ctrl.regWrite = 1'b1;
                aluOp = aluOpRType;
            end
            opIType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                aluOp = aluOpIType;
            end
            opBranch: begin
                ctrl.branch = 1'b1;
                immSrc = immB;
                aluOp = aluOpSub;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.resultSrc = resPcPlus4;
                immSrc = immJ;
            end
            default: begin
                // Bubble.
                aluOp = aluOpAdd;
            end
        endcase
    end

    // ALU decoder.
    always_comb begin
        ctrl.aluControl = aluAdd;
        case (aluOp)
            aluOpAdd: begin
                ctrl.aluControl = aluAdd;
            end
            aluOpSub: begin
                ctrl.aluControl = aluSub;
            end
            default: begin
                case (funct3)
                    3'b000: begin
                        // Only R-type can subtract here, addi keeps imm[10] out of it.
                        if (aluOp == aluOpRType && funct7b5) begin
                            ctrl.aluControl = aluSub;
                        end else begin
                            ctrl.aluControl = aluAdd;
                        end
                    end
                    3'b010: begin
                        ctrl.aluControl = aluSlt;
                    end
                    3'b110: begin
                        ctrl.aluControl = aluOr;
                    end
                    3'b111: begin
                        ctrl.aluControl = aluAnd;
                    end
                    default: begin
                        ctrl.aluControl = aluAdd;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import rvDecodePkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [wordWidth-1:0] instr,
    input  logic [wordWidth-1:0] pc,
    input  logic [wordWidth-1:0] pcPlus4,
    input  wbT                   wb,
    output execBundleT           exec
);

    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    opcodeE                  opcode;

    ctrlT                 ctrl;
    immSrcE               immSrc;
    logic [wordWidth-1:0] immExt;
    logic [wordWidth-1:0] rd1;
    logic [wordWidth-1:0] rd2;
    execBundleT           execNext;

    // Instruction fields.
    assign opcode = opcodeE'(instr[6:0]);
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    controlUnit uControl (
        .opcode   (opcode),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .ctrl     (ctrl),
        .immSrc   (immSrc)
    );

    immExtender uImm (
        .instrBits (instr[31:7]),
        .immSrc    (immSrc),
        .immExt    (immExt)
    );

    registerFile uRegs (
        .clk (clk),
        .rst (rst),
        .rs1 (rs1),
        .rs2 (rs2),
        .wb  (wb),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        execNext.rd1 = rd1;
        execNext.rd2 = rd2;
        execNext.pc = pc;
        execNext.pcPlus4 = pcPlus4;
        execNext.rs1 = rs1;
        execNext.rs2 = rs2;
        execNext.rd = rd;
        execNext.immExt = immExt;
        execNext.ctrl = ctrl;
    end

    // Decode to execute register, loads every cycle.
    // Reset leaves a bubble in execute.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exec <= '0;
        end else begin
            exec <= execNext;
        end
    end

endmodule

`default_nettype wire

//--- hw/immExtender.sv
`timescale 1ns/1ps
`default_nettype none

module immExtender import rvDecodePkg::*; (
    input  logic [24:0]          instrBits,
    input  immSrcE               immSrc,
    output logic [wordWidth-1:0] immExt
);

    // instrBits[k] is instruction bit k+7.
    logic signBit;

    assign signBit = instrBits[24];

    always_comb begin
        case (immSrc)
            immI: begin
                immExt = {{20{signBit}}, instrBits[24:13]};
            end
            immS: begin
                immExt = {{20{signBit}}, instrBits[24:18], instrBits[4:0]};
            end
            immB: begin
                // imm[12|10:5|4:1|11], bit 0 is implied.
                immExt = {{20{signBit}}, instrBits[0], instrBits[23:18],
                          instrBits[4:1], 1'b0};
            end
            immJ: begin
                // imm[20|10:1|11|19:12].
                immExt = {{12{signBit}}, instrBits[12:5], instrBits[13],
                          instrBits[23:14], 1'b0};
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvDecodePkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    input  wbT                      wb,
    output logic [wordWidth-1:0]    rd1,
    output logic [wordWidth-1:0]    rd2
);

    // x0 has no storage.
    logic [wordWidth-1:0] regs [1:numRegs-1];

    // Read with write-to-read bypass.
    function automatic logic [wordWidth-1:0] readPort(
        input logic [regAddrWidth-1:0] addr
    );
        logic [wordWidth-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wb.regWrite && wb.rd == addr) begin
            value = wb.result;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

endmodule

`default_nettype wire

//--- hw/rvDecodePkg.sv
`default_nettype none

package rvDecodePkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs = 32;

    // RV32I major opcodes handled by the decoder.
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRType  = 7'b0110011,
        opIType  = 7'b0010011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeE;

    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrcE;

    // Selects what the writeback stage returns to the register file.
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrcE;

    // Encoding follows the execute-stage ALU.
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluControlE;

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       jump;
        logic       branch;
        logic       aluSrc;
        resultSrcE  resultSrc;
        aluControlE aluControl;
    } ctrlT;

    // Write port driven by the writeback stage.
    typedef struct packed {
        logic                    regWrite;
        logic [regAddrWidth-1:0] rd;
        logic [wordWidth-1:0]    result;
    } wbT;

    // Decode to execute pipeline register contents.
    typedef struct packed {
        logic [wordWidth-1:0]    rd1;
        logic [wordWidth-1:0]    rd2;
        logic [wordWidth-1:0]    pc;
        logic [wordWidth-1:0]    pcPlus4;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
        logic [wordWidth-1:0]    immExt;
        ctrlT                    ctrl;
    } execBundleT;

endpackage

`default_nettype wire

//--- rvDecode.f
hw/rvDecodePkg.sv
hw/controlUnit.sv
hw/immExtender.sv
hw/registerFile.sv
hw/decodeStage.sv
tb/decodeStage_assertions.sv
tb/decodeStageTb.sv

//--- tb/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb import rvDecodePkg::*; ();

    localparam int resetTimeout = 20;

    typedef struct packed {
        logic [wordWidth-1:0] instr;
        logic [wordWidth-1:0] pc;
        wbT                   wb;
        ctrlT                 ctrl;
        logic [wordWidth-1:0] imm;
        logic                 immValid;
    } rowT;

    logic                 clk;
    logic                 rst;
    logic [wordWidth-1:0] instr;
    logic [wordWidth-1:0] pc;
    logic [wordWidth-1:0] pcPlus4;
    wbT                   wb;
    execBundleT           exec;

    rowT                  rows [$];
    logic [wordWidth-1:0] model [0:numRegs-1];
    execBundleT           expected;
    logic                 expImmValid;

    decodeStage DUT (
        .clk     (clk),
        .rst     (rst),
        .instr   (instr),
        .pc      (pc),
        .pcPlus4 (pcPlus4),
        .wb      (wb),
        .exec    (exec)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opRType};
    endfunction

    function automatic logic [31:0] encodeI(input logic [31:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input opcodeE op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encodeS(input logic [31:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encodeB(input logic [31:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    function automatic ctrlT ctrlOf(input logic rw, input logic mw, input logic j,
                                    input logic b, input logic as, input resultSrcE rs,
                                    input aluControlE ac);
        ctrlT c;
        c.regWrite = rw;
        c.memWrite = mw;
        c.jump = j;
        c.branch = b;
        c.aluSrc = as;
        c.resultSrc = rs;
        c.aluControl = ac;
        return c;
    endfunction

    // Register read as seen by decode, including the same-cycle write.
    function automatic logic [31:0] modelRead(input logic [4:0] addr, input wbT w);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = '0;
        end else if (w.regWrite && w.rd == addr) begin
            value = w.result;
        end else begin
            value = model[addr];
        end
        return value;
    endfunction

    task automatic addRow(input logic [31:0] code, input logic wen, input logic [4:0] wrd,
                          input ctrlT c, input logic [31:0] imm, input logic immValid);
        rowT row;
        row.instr = code;
        row.pc = $urandom & 32'hFFFF_FFFC;
        row.wb.regWrite = wen;
        row.wb.rd = wrd;
        row.wb.result = $urandom;
        row.ctrl = c;
        row.imm = imm;
        row.immValid = immValid;
        rows.push_back(row);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expValue);
        if (actual !== expValue) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expValue);
            $display("sim failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic checkBundle(input execBundleT exp, input logic immValid);
        checkValue("rd1", exec.rd1, exp.rd1);
        checkValue("rd2", exec.rd2, exp.rd2);
        checkValue("pc", exec.pc, exp.pc);
        checkValue("pcPlus4", exec.pcPlus4, exp.pcPlus4);
        checkValue("rs1", {27'b0, exec.rs1}, {27'b0, exp.rs1});
        checkValue("rs2", {27'b0, exec.rs2}, {27'b0, exp.rs2});
        checkValue("rd", {27'b0, exec.rd}, {27'b0, exp.rd});
        checkValue("ctrl", {22'b0, exec.ctrl}, {22'b0, exp.ctrl});
        if (immValid) begin
            checkValue("immExt", exec.immExt, exp.immExt);
        end
    endtask

    // Drives one row and records what exec must hold after the next edge.
    task automatic driveRow(input rowT row);
        instr = row.instr;
        pc = row.pc;
        pcPlus4 = row.pc + 32'd4;
        wb = row.wb;
        expected.rs1 = row.instr[19:15];
        expected.rs2 = row.instr[24:20];
        expected.rd = row.instr[11:7];
        expected.rd1 = modelRead(row.instr[19:15], row.wb);
        expected.rd2 = modelRead(row.instr[24:20], row.wb);
        expected.pc = row.pc;
        expected.pcPlus4 = row.pc + 32'd4;
        expected.immExt = row.imm;
        expected.ctrl = row.ctrl;
        expImmValid = row.immValid;
        if (row.wb.regWrite && row.wb.rd != 5'd0) begin
            model[row.wb.rd] = row.wb.result;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        // A store held during reset must not reach execute.
        instr = encodeS(32'h0000_0123, 5'd5, 5'd6);
        pc = 32'h0000_0100;
        pcPlus4 = 32'h0000_0104;
        wb = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        instr = '0;
        pc = '0;
        pcPlus4 = '0;
    end

    initial begin
        int waited;
        void'($urandom(32'h1745_88ed));
        for (int i = 0; i < numRegs; i++) begin
            model[i] = '0;
        end

        addRow(encodeI(5, 0, 3'b000, 1, opIType), 1'b1, 5'd1,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, resAlu, aluAdd), 5, 1'b1);
        // Immediate bit 10 set must still add.
        addRow(encodeI(-7, 1, 3'b000, 2, opIType), 1'b1, 5'd2,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, resAlu, aluAdd), -7, 1'b1);
        addRow(encodeR(7'b0000000, 2, 1, 3'b000, 3), 1'b1, 5'd3,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, aluAdd), 0, 1'b0);
        addRow(encodeR(7'b0100000, 1, 3, 3'b000, 4), 1'b1, 5'd0,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, aluSub), 0, 1'b0);
        // Write to x0 while reading it.
        addRow(encodeR(7'b0000000, 2, 0, 3'b111, 5), 1'b1, 5'd0,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, aluAnd), 0, 1'b0);
        // Bypass on rs1.
        addRow(encodeR(7'b0000000, 3, 7, 3'b110, 6), 1'b1, 5'd7,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, aluOr), 0, 1'b0);
        addRow(encodeR(7'b0000000, 7, 2, 3'b010, 8), 1'b1, 5'd2,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, aluSlt), 0, 1'b0);
        addRow(encodeI(32'h7F0, 3, 3'b111, 9, opIType), 1'b1, 5'd9,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, resAlu, aluAnd), 32'h7F0, 1'b1);
        addRow(encodeI(-1, 9, 3'b110, 10, opIType), 1'b1, 5'd10,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, resAlu, aluOr), -1, 1'b1);
        addRow(encodeI(-2048, 4, 3'b010, 11, opIType), 1'b1, 5'd11,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, resAlu, aluSlt), -2048, 1'b1);
        addRow(encodeI(-12, 1, 3'b010, 12, opLoad), 1'b1, 5'd12,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, resMem, aluAdd), -12, 1'b1);
        // Bypass on rs2.
        addRow(encodeS(2047, 13, 2), 1'b1, 5'd13,
               ctrlOf(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, resAlu, aluAdd), 2047, 1'b1);
        addRow(encodeS(-100, 14, 0), 1'b0, 5'd0,
               ctrlOf(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, resAlu, aluAdd), -100, 1'b1);
        addRow(encodeB(-4096, 2, 1), 1'b1, 5'd14,
               ctrlOf(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, resAlu, aluSub), -4096, 1'b1);
        addRow(encodeB(2014, 14, 15), 1'b1, 5'd15,
               ctrlOf(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, resAlu, aluSub), 2014, 1'b1);
        addRow(encodeJ(-1048576, 1), 1'b1, 5'd16,
               ctrlOf(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, resPcPlus4, aluAdd), -1048576, 1'b1);
        addRow(encodeJ(524286, 5), 1'b0, 5'd0,
               ctrlOf(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, resPcPlus4, aluAdd), 524286, 1'b1);
        // lui and ecall are outside the subset.
        addRow(32'hABCD_EFB7, 1'b1, 5'd31, '0, 0, 1'b0);
        addRow(32'h0000_0073, 1'b0, 5'd0, '0, 0, 1'b0);
        addRow(encodeR(7'b0000000, 16, 31, 3'b000, 20), 1'b0, 5'd0,
               ctrlOf(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, resAlu, aluAdd), 0, 1'b0);

        // Execute stays empty while reset is held against a live store.
        @(negedge clk);
        checkBundle('0, 1'b1);

        waited = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > resetTimeout) begin
                $display("Reset was never released");
                $display("sim failed");
                $fatal(1, "reset timeout");
            end
        end

        // Nothing valid has been decoded yet.
        @(negedge clk);
        checkBundle('0, 1'b1);

        for (int i = 0; i < rows.size(); i++) begin
            if (i > 0) begin
                checkBundle(expected, expImmValid);
            end
            driveRow(rows[i]);
            @(negedge clk);
        end
        checkBundle(expected, expImmValid);

        if (DUT.assertChecks.failCount == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("%0d assertion failures", DUT.assertChecks.failCount);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

//--- tb/decodeStage_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage_assertions import rvDecodePkg::*; (
    input wire logic       clk,
    input wire logic       rst,
    input wire opcodeE     opcode,
    input wire execBundleT exec
);

    int failCount = 0;

    // Reset leaves a bubble in execute.
    resetBubble: assert property (@(posedge clk) rst |=> exec.ctrl == '0)
        else begin
            failCount++;
            $error("exec.ctrl not zero after reset");
        end

    // Reads of x0 are zero once registered.
    zeroRs1: assert property (@(posedge clk) disable iff (rst)
        exec.rs1 == '0 |-> exec.rd1 == '0)
        else begin
            failCount++;
            $error("rd1 nonzero for rs1 of x0");
        end

    zeroRs2: assert property (@(posedge clk) disable iff (rst)
        exec.rs2 == '0 |-> exec.rd2 == '0)
        else begin
            failCount++;
            $error("rd2 nonzero for rs2 of x0");
        end

    // Unknown opcodes must not reach execute as a store.
    bubbleNoStore: assert property (@(posedge clk) disable iff (rst)
        !(opcode inside {opLoad, opStore, opRType, opIType, opBranch, opJal})
        |=> !exec.ctrl.memWrite)
        else begin
            failCount++;
            $error("memWrite set in execute for an unknown opcode");
        end

endmodule

bind decodeStage decodeStage_assertions assertChecks (
    .clk    (clk),
    .rst    (rst),
    .opcode (opcode),
    .exec   (exec)
);

`default_nettype wire
